// ==== flist.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_regfile.sv
rtl/ex_issue_stage.sv
rtl/ex_dispatch.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_writeback.sv
rtl/ex_top.sv
tb/ex_clock_gen.sv
tb/ex_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module ex_tb -o ex_sim \
    && ./obj_dir/ex_sim 2>&1 \
    | awk '{ print } /Simulation completed successfully/ { ok = 1 } END { exit !ok }' \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== tb/ex_tb.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_tb;

    import ex_pkg::*;

    localparam int RESET_CYCLES   = 2;
    localparam int CYCLES_PER_ROW = 20;

    logic                  cpu_clock;
    logic                  rst;
    logic                  flush;
    logic                  req;
    logic                  ack;
    ex_entry_t             entry;
    logic [`EX_PREG_W-1:0] wakeup_dest;
    logic                  wakeup_valid;
    ex_done_t              done;
    logic                  done_valid;
    logic                  redirect_valid;

    // stimulus table, one element per row in every queue.
    string       row_name[$];
    ex_entry_t   row_entry[$];
    logic        row_rnd[$];   // replace imm with an lfsr word.
    logic        row_flush[$];
    logic        row_taken[$];
    logic        row_misp[$];

    logic [`EX_XLEN-1:0] shadow [`EX_NPREG];
    logic [31:0]         lfsr_state;
    bit                  rows_loaded;

    ex_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clk_gen (
        .cpu_clock_o (cpu_clock),
        .rst_o       (rst)
    );

    ex_top dut0 (
        .cpu_clock_i      (cpu_clock),
        .rst_i            (rst),
        .flush_i          (flush),
        .req_i            (req),
        .ack_o            (ack),
        .entry_i          (entry),
        .wakeup_dest_o    (wakeup_dest),
        .wakeup_valid_o   (wakeup_valid),
        .done_o           (done),
        .done_valid_o     (done_valid),
        .redirect_valid_o (redirect_valid)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input string field,
                                input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            abort_run($sformatf("[ERROR] %s %s: expected %h, actual %h", name, field, exp, got));
        end
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]}; // one step per bit.
        end
        return w;
    endfunction

    function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            `EX_OP_ADD: return a + b;
            `EX_OP_SUB: return a + ~b + 32'd1;
            `EX_OP_AND: return a & b;
            `EX_OP_OR:  return a | b;
            `EX_OP_XOR: return a ^ b;
            `EX_OP_SLT: return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            `EX_OP_SLL: return a << b[4:0];
            `EX_OP_SRL: return a >> b[4:0];
            default:    return 32'd0;
        endcase
    endfunction

    task automatic add_row(input string name, input ex_entry_t e, input logic rnd,
                           input logic fl, input logic taken, input logic misp);
        e.rob_id = 5'(row_name.size());
        row_name.push_back(name);
        row_entry.push_back(e);
        row_rnd.push_back(rnd);
        row_flush.push_back(fl);
        row_taken.push_back(taken);
        row_misp.push_back(misp);
    endtask

    task automatic lui_row(input string name, input int dest, input logic [31:0] imm,
                           input logic rnd, input logic fl);
        ex_entry_t e;
        e = '0;
        e.kind = LUI;
        e.dest = 6'(dest);
        e.imm  = imm;
        add_row(name, e, rnd, fl, 1'b0, 1'b0);
    endtask

    task automatic alu_row(input string name, input logic [3:0] op, input int rs1,
                           input int rs2, input int dest, input logic use_imm);
        ex_entry_t e;
        e = '0;
        e.kind    = ALU;
        e.op      = op;
        e.rs1     = 6'(rs1);
        e.rs2     = 6'(rs2);
        e.dest    = 6'(dest);
        e.use_imm = use_imm;
        add_row(name, e, use_imm, 1'b0, 1'b0, 1'b0); // immediates come from the lfsr.
    endtask

    task automatic flow_row(input string name, input ex_kind_e kind, input logic [2:0] cond,
                            input int rs1, input int rs2, input int dest,
                            input logic [31:0] imm, input logic [29:0] pc, input logic pt,
                            input logic bvld, input logic [29:0] btgt,
                            input logic taken, input logic misp);
        ex_entry_t e;
        e = '0;
        e.kind       = kind;
        e.op         = {1'b0, cond};
        e.rs1        = 6'(rs1);
        e.rs2        = 6'(rs2);
        e.dest       = 6'(dest);
        e.imm        = imm;
        e.pc         = pc;
        e.bm_pred    = {pt, 1'b0};
        e.btb_vld    = bvld;
        e.btb_target = btgt;
        add_row(name, e, 1'b0, 1'b0, taken, misp);
    endtask

    task automatic build_table();
        lui_row("lui_r1", 1, 32'h0, 1'b1, 1'b0);
        lui_row("lui_r2", 2, 32'h0, 1'b1, 1'b0);
        lui_row("lui_r3", 3, 32'h0000_0010, 1'b0, 1'b0);
        lui_row("lui_r4", 4, 32'hffff_fff0, 1'b0, 1'b0);
        lui_row("lui_r5", 5, 32'h0000_0010, 1'b0, 1'b0);
        alu_row("add_rr", `EX_OP_ADD, 1, 2, 6, 1'b0); // reads back the first two loads.
        alu_row("sub_rr", `EX_OP_SUB, 1, 2, 7, 1'b0);
        alu_row("and_rr", `EX_OP_AND, 1, 2, 8, 1'b0);
        alu_row("or_rr", `EX_OP_OR, 1, 2, 9, 1'b0);
        alu_row("xor_rr", `EX_OP_XOR, 1, 2, 10, 1'b0);
        alu_row("slt_rr", `EX_OP_SLT, 1, 2, 11, 1'b0);
        alu_row("sll_rr", `EX_OP_SLL, 1, 2, 12, 1'b0);
        alu_row("srl_rr", `EX_OP_SRL, 1, 2, 13, 1'b0);
        alu_row("add_ri", `EX_OP_ADD, 2, 0, 14, 1'b1);
        alu_row("sub_ri", `EX_OP_SUB, 2, 0, 15, 1'b1);
        alu_row("and_ri", `EX_OP_AND, 2, 0, 16, 1'b1);
        alu_row("or_ri", `EX_OP_OR, 2, 0, 17, 1'b1);
        alu_row("xor_ri", `EX_OP_XOR, 2, 0, 18, 1'b1);
        alu_row("slt_ri", `EX_OP_SLT, 2, 0, 19, 1'b1);
        alu_row("sll_ri", `EX_OP_SLL, 2, 0, 20, 1'b1);
        alu_row("srl_ri", `EX_OP_SRL, 2, 0, 21, 1'b1);
        alu_row("slt_signed", `EX_OP_SLT, 4, 3, 22, 1'b0);
        lui_row("lui_x0", 0, 32'h0000_1234, 1'b0, 1'b0);
        // r3 and r5 hold 16, r4 holds -16.
        flow_row("beq_taken", BRANCH, 3'b000, 3, 5, 0, 32'h40, 30'h100,
                 1'b1, 1'b1, 30'h110, 1'b1, 1'b0);
        flow_row("bne_not_taken", BRANCH, 3'b001, 3, 5, 0, 32'h40, 30'h100,
                 1'b0, 1'b0, 30'h0, 1'b0, 1'b0);
        flow_row("blt_taken", BRANCH, 3'b100, 4, 3, 0, 32'hffff_fff0, 30'h100,
                 1'b0, 1'b0, 30'h0, 1'b1, 1'b1);
        flow_row("bge_not_taken", BRANCH, 3'b101, 4, 3, 0, 32'h40, 30'h100,
                 1'b1, 1'b1, 30'h120, 1'b0, 1'b1);
        flow_row("bltu_not_taken", BRANCH, 3'b110, 4, 3, 0, 32'h40, 30'h100,
                 1'b0, 1'b1, 30'h130, 1'b0, 1'b0);
        flow_row("bgeu_bad_btb", BRANCH, 3'b111, 4, 3, 30, 32'h20, 30'h100,
                 1'b1, 1'b1, 30'h10c, 1'b1, 1'b1);
        flow_row("jal", JAL, 3'b000, 0, 0, 23, 32'h100, 30'h200,
                 1'b1, 1'b1, 30'h240, 1'b1, 1'b0);
        alu_row("jal_link", `EX_OP_ADD, 23, 0, 24, 1'b0);
        flow_row("jalr", JALR, 3'b000, 3, 0, 25, 32'h1000, 30'h300,
                 1'b0, 1'b0, 30'h0, 1'b1, 1'b1);
        alu_row("jalr_link", `EX_OP_ADD, 25, 0, 26, 1'b0);
        flow_row("jal_x0", JAL, 3'b000, 0, 0, 0, 32'h8, 30'h50,
                 1'b1, 1'b0, 30'h0, 1'b1, 1'b1);
        flow_row("auipc", AUIPC, 3'b000, 0, 0, 27, 32'h1234_5000, 30'h400,
                 1'b0, 1'b0, 30'h0, 1'b0, 1'b0);
        lui_row("lui_flushed", 28, 32'hdead_beef, 1'b0, 1'b1);
        alu_row("add_after_flush", `EX_OP_ADD, 28, 0, 29, 1'b0);
    endtask

    task automatic run_row(input int i);
        ex_entry_t           e;
        string               nm;
        logic [`EX_XLEN-1:0] b;
        logic [`EX_XLEN-1:0] exp_data;
        logic [`EX_XLEN-1:0] jsum;
        logic [29:0]         exp_target;
        logic                alu_class;
        logic                exp_wr;
        e  = row_entry[i];
        nm = row_name[i];
        if (row_rnd[i]) begin
            e.imm = rand_word();
        end
        b         = e.use_imm ? e.imm : shadow[e.rs2];
        alu_class = (e.kind == ALU) || (e.kind == LUI) || (e.kind == AUIPC);
        exp_wr    = (e.kind != BRANCH) && (e.dest != '0);
        jsum      = shadow[e.rs1] + e.imm;
        case (e.kind)
            LUI:     exp_data = e.imm;
            AUIPC:   exp_data = {e.pc, 2'b00} + e.imm;
            ALU:     exp_data = alu_model(e.op, shadow[e.rs1], b);
            default: exp_data = {e.pc + 30'd1, 2'b00}; // link address.
        endcase
        if (e.kind == JALR) begin
            exp_target = jsum[31:2];
        end else if (e.kind == JAL || row_taken[i]) begin
            exp_target = e.pc + e.imm[31:2];
        end else begin
            exp_target = e.pc + 30'd1;
        end
        if (exp_wr && !row_flush[i]) begin
            shadow[e.dest] = exp_data;
        end

        @(posedge cpu_clock);
        req   <= 1'b1;
        entry <= e;
        do @(negedge cpu_clock); while (!ack);
        @(posedge cpu_clock);
        req <= 1'b0;
        if (row_flush[i]) begin
            flush <= 1'b1; // sampled one edge after the capture.
        end
        @(negedge cpu_clock);
        expect_equal(nm, "wakeup_valid", 32'(exp_wr), 32'(wakeup_valid));
        if (exp_wr) begin
            expect_equal(nm, "wakeup_dest", 32'(e.dest), 32'(wakeup_dest));
        end
        expect_equal(nm, "early done_valid", 32'd0, 32'(done_valid));
        @(posedge cpu_clock);
        flush <= 1'b0;
        @(negedge cpu_clock);
        expect_equal(nm, "late wakeup_valid", 32'd0, 32'(wakeup_valid));
        expect_equal(nm, "early done_valid", 32'd0, 32'(done_valid));
        @(negedge cpu_clock);
        expect_equal(nm, "ack released", 32'd0, 32'(ack));
        expect_equal(nm, "done_valid", 32'(!row_flush[i]), 32'(done_valid));
        if (!row_flush[i]) begin
            expect_equal(nm, "rob_id", 32'(e.rob_id), 32'(done.rob_id));
            expect_equal(nm, "wr_en", 32'(exp_wr), 32'(done.wr_en));
            expect_equal(nm, "is_branch", 32'(!alu_class), 32'(done.is_branch));
            if (exp_wr) begin
                expect_equal(nm, "dest", 32'(e.dest), 32'(done.dest));
            end
            if (alu_class) begin
                expect_equal(nm, "data", exp_data, done.result.data);
                expect_equal(nm, "redirect_valid", 32'd0, 32'(redirect_valid));
            end else begin
                expect_equal(nm, "taken", 32'(row_taken[i]), 32'(done.result.redir.taken));
                expect_equal(nm, "mispredict", 32'(row_misp[i]),
                             32'(done.result.redir.mispredict));
                expect_equal(nm, "target", 32'(exp_target), 32'(done.result.redir.target));
                expect_equal(nm, "redirect_valid", 32'(row_misp[i]), 32'(redirect_valid));
            end
        end else begin
            expect_equal(nm, "redirect_valid", 32'd0, 32'(redirect_valid));
        end
    endtask

    initial begin
        req         = 1'b0;
        flush       = 1'b0;
        entry       = '0;
        rows_loaded = 1'b0;
        lfsr_state  = 32'ha49b;
        for (int r = 0; r < `EX_NPREG; r++) begin
            shadow[r] = '0; // matches the register file after reset.
        end
        build_table();
        rows_loaded = 1'b1;
        do @(posedge cpu_clock); while (rst !== 1'b0);
        for (int i = 0; i < row_name.size(); i++) begin
            run_row(i);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        wait (rows_loaded);
        repeat (RESET_CYCLES + CYCLES_PER_ROW * row_name.size()) @(posedge cpu_clock);
        abort_run("watchdog expired before the table finished, the DUT stopped responding");
    end

endmodule

// ==== tb/ex_clock_gen.sv ====
`timescale 1ns/1ps

module ex_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic cpu_clock_o,
    output logic rst_o
);

    initial begin
        cpu_clock_o = 1'b0;
        forever #HALF_PERIOD cpu_clock_o = ~cpu_clock_o; // 8 ns period.
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge cpu_clock_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== rtl/ex_top.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_top (
    input  logic                  cpu_clock_i,
    input  logic                  rst_i,
    input  logic                  flush_i,

    input  logic                  req_i,
    output logic                  ack_o,
    input  ex_pkg::ex_entry_t     entry_i,

    output logic [`EX_PREG_W-1:0] wakeup_dest_o,
    output logic                  wakeup_valid_o,

    output ex_pkg::ex_done_t      done_o,
    output logic                  done_valid_o,
    output logic                  redirect_valid_o
);

    import ex_pkg::*;

    logic [`EX_PREG_W-1:0] rs1_addr;
    logic [`EX_PREG_W-1:0] rs2_addr;
    logic [`EX_XLEN-1:0]   rs1_data;
    logic [`EX_XLEN-1:0]   rs2_data;
    ex_entry_t             iss_entry;
    logic                  iss_valid;
    ex_alu_req_t           alu_req;
    ex_bnch_req_t          bnch_req;
    logic [`EX_ROB_W-1:0]  alu_rob_id;
    logic [`EX_PREG_W-1:0] alu_dest;
    logic [`EX_XLEN-1:0]   alu_data;
    logic                  alu_valid;
    ex_bnch_res_t          bnch_res;
    logic                  rf_wr_en;
    logic [`EX_PREG_W-1:0] rf_wr_addr;
    logic [`EX_XLEN-1:0]   rf_wr_data;

    ex_issue_stage u_issue (
        .cpu_clock_i   (cpu_clock_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .entry_i       (entry_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .entry_o       (iss_entry),
        .entry_valid_o (iss_valid)
    );

    ex_regfile u_regfile (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .wr_en_i     (rf_wr_en),
        .wr_addr_i   (rf_wr_addr),
        .wr_data_i   (rf_wr_data)
    );

    ex_dispatch u_dispatch (
        .cpu_clock_i    (cpu_clock_i),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .entry_i        (iss_entry),
        .entry_valid_i  (iss_valid),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .alu_req_o      (alu_req),
        .bnch_req_o     (bnch_req),
        .wakeup_dest_o  (wakeup_dest_o),
        .wakeup_valid_o (wakeup_valid_o)
    );

    ex_alu u_alu (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .req_i       (alu_req),
        .rob_id_o    (alu_rob_id),
        .dest_o      (alu_dest),
        .data_o      (alu_data),
        .valid_o     (alu_valid)
    );

    ex_branch_unit u_branch (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .req_i       (bnch_req),
        .res_o       (bnch_res)
    );

    ex_writeback u_writeback (
        .cpu_clock_i  (cpu_clock_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .alu_rob_id_i (alu_rob_id),
        .alu_dest_i   (alu_dest),
        .alu_data_i   (alu_data),
        .alu_valid_i  (alu_valid),
        .bnch_res_i   (bnch_res),
        .rf_wr_en_o   (rf_wr_en),
        .rf_wr_addr_o (rf_wr_addr),
        .rf_wr_data_o (rf_wr_data),
        .done_o       (done_o),
        .done_valid_o (done_valid_o)
    );

    // fetch is redirected only for a completed branch that went the wrong way.
    assign redirect_valid_o = done_valid_o && done_o.is_branch
                              && done_o.result.redir.mispredict;

endmodule

// ==== rtl/ex_writeback.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_writeback (
    input  logic                  cpu_clock_i,
    input  logic                  rst_i,
    input  logic                  flush_i,

    input  logic [`EX_ROB_W-1:0]  alu_rob_id_i,
    input  logic [`EX_PREG_W-1:0] alu_dest_i,
    input  logic [`EX_XLEN-1:0]   alu_data_i,
    input  logic                  alu_valid_i,
    input  ex_pkg::ex_bnch_res_t  bnch_res_i,

    output logic                  rf_wr_en_o,
    output logic [`EX_PREG_W-1:0] rf_wr_addr_o,
    output logic [`EX_XLEN-1:0]   rf_wr_data_o,

    output ex_pkg::ex_done_t      done_o,
    output logic                  done_valid_o
);

    import ex_pkg::*;

    ex_done_t done_d;
    logic     any_valid;

    assign any_valid = alu_valid_i || bnch_res_i.valid;

    // the two units never finish on the same cycle since issue is spaced out.
    always_comb begin
        if (alu_valid_i) begin
            done_d.rob_id      = alu_rob_id_i;
            done_d.dest        = alu_dest_i;
            done_d.is_branch   = 1'b0;
            done_d.result.data = alu_data_i;
            rf_wr_data_o       = alu_data_i;
        end else begin
            done_d.rob_id    = bnch_res_i.rob_id;
            done_d.dest      = bnch_res_i.dest;
            done_d.is_branch = 1'b1;
            done_d.result    = bnch_res_i.redirect;
            rf_wr_data_o     = bnch_res_i.link; // only jumps carry a nonzero dest.
        end
        done_d.wr_en = done_d.dest != '0;
    end

    assign rf_wr_en_o   = any_valid && done_d.wr_en && !flush_i;
    assign rf_wr_addr_o = done_d.dest;

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            done_valid_o <= 1'b0;
        end else begin
            done_valid_o <= any_valid && !flush_i;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        done_o <= done_d;
    end

endmodule

// ==== rtl/ex_branch_unit.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_branch_unit (
    input  logic                 cpu_clock_i,
    input  logic                 rst_i,
    input  logic                 flush_i,

    input  ex_pkg::ex_bnch_req_t req_i,
    output ex_pkg::ex_bnch_res_t res_o
);

    import ex_pkg::*;

    logic                cond_met;
    logic                taken;
    logic [`EX_PC_W-1:0] pc_next;
    logic [`EX_PC_W-1:0] rel_target;
    logic [`EX_XLEN-1:0] jalr_sum;
    logic [`EX_PC_W-1:0] target;
    logic [`EX_PC_W-1:0] pred_next;
    ex_bnch_res_t        res_d;

    assign pc_next    = req_i.pc + 1'b1;
    assign rel_target = req_i.pc + req_i.offset[31:2]; // offset is in bytes.
    assign jalr_sum   = req_i.op1 + req_i.offset;

    // condition codes follow the RISC-V funct3 encoding.
    always_comb begin
        case (req_i.cond)
            3'b000:  cond_met = req_i.op1 == req_i.op2;
            3'b001:  cond_met = req_i.op1 != req_i.op2;
            3'b100:  cond_met = $signed(req_i.op1) < $signed(req_i.op2);
            3'b101:  cond_met = $signed(req_i.op1) >= $signed(req_i.op2);
            3'b110:  cond_met = req_i.op1 < req_i.op2;
            3'b111:  cond_met = req_i.op1 >= req_i.op2;
            default: cond_met = 1'b0;
        endcase
    end

    always_comb begin
        case (req_i.kind)
            JAL: begin
                taken  = 1'b1;
                target = rel_target;
            end
            JALR: begin
                taken  = 1'b1;
                target = jalr_sum[31:2];
            end
            default: begin
                taken  = cond_met;
                target = cond_met ? rel_target : pc_next;
            end
        endcase
    end

    // the front end went to the btb target only on a taken prediction with a hit.
    assign pred_next = (req_i.btb_vld && req_i.pred_taken) ? req_i.btb_target : pc_next;

    always_comb begin
        res_d.rob_id                    = req_i.rob_id;
        res_d.dest                      = (req_i.kind == BRANCH) ? '0 : req_i.dest;
        res_d.link                      = {pc_next, 2'b00};
        res_d.redirect.redir.taken      = taken;
        res_d.redirect.redir.mispredict = pred_next != target;
        res_d.redirect.redir.target     = target;
        res_d.valid                     = req_i.valid && !flush_i;
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o <= res_d;
        end
    end

endmodule

// ==== rtl/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_alu (
    input  logic                  cpu_clock_i,
    input  logic                  rst_i,
    input  logic                  flush_i,

    input  ex_pkg::ex_alu_req_t   req_i,

    output logic [`EX_ROB_W-1:0]  rob_id_o,
    output logic [`EX_PREG_W-1:0] dest_o,
    output logic [`EX_XLEN-1:0]   data_o,
    output logic                  valid_o
);

    logic [`EX_XLEN-1:0] result;
    logic [4:0]          shamt;

    assign shamt = req_i.b[4:0];

    always_comb begin
        case (req_i.op)
            `EX_OP_ADD: result = req_i.a + req_i.b;
            `EX_OP_SUB: result = req_i.a - req_i.b;
            `EX_OP_AND: result = req_i.a & req_i.b;
            `EX_OP_OR:  result = req_i.a | req_i.b;
            `EX_OP_XOR: result = req_i.a ^ req_i.b;
            `EX_OP_SLT: result = {31'd0, $signed(req_i.a) < $signed(req_i.b)};
            `EX_OP_SLL: result = req_i.a << shamt;
            `EX_OP_SRL: result = req_i.a >> shamt; // logical shift.
            default:    result = '0;
        endcase
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= req_i.valid && !flush_i;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (req_i.valid) begin
            rob_id_o <= req_i.rob_id;
            dest_o   <= req_i.dest;
            data_o   <= result;
        end
    end

endmodule

// ==== rtl/ex_dispatch.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_dispatch (
    input  logic                  cpu_clock_i,
    input  logic                  rst_i,
    input  logic                  flush_i,

    input  ex_pkg::ex_entry_t     entry_i,
    input  logic                  entry_valid_i,
    input  logic [`EX_XLEN-1:0]   rs1_data_i,
    input  logic [`EX_XLEN-1:0]   rs2_data_i,

    output ex_pkg::ex_alu_req_t   alu_req_o,
    output ex_pkg::ex_bnch_req_t  bnch_req_o,

    output logic [`EX_PREG_W-1:0] wakeup_dest_o,
    output logic                  wakeup_valid_o
);

    import ex_pkg::*;

    ex_alu_req_t  alu_d;
    ex_bnch_req_t bnch_d;
    logic         live;
    logic         to_alu;

    assign live   = entry_valid_i && !flush_i;
    assign to_alu = (entry_i.kind == ALU) || (entry_i.kind == LUI) || (entry_i.kind == AUIPC);

    always_comb begin
        alu_d.rob_id = entry_i.rob_id;
        alu_d.dest   = entry_i.dest;
        alu_d.valid  = live && to_alu;
        case (entry_i.kind)
            LUI: begin
                alu_d.a  = '0;
                alu_d.b  = entry_i.imm;
                alu_d.op = `EX_OP_ADD;
            end
            AUIPC: begin
                alu_d.a  = {entry_i.pc, 2'b00}; // byte address of the instruction.
                alu_d.b  = entry_i.imm;
                alu_d.op = `EX_OP_ADD;
            end
            default: begin
                alu_d.a  = rs1_data_i;
                alu_d.b  = entry_i.use_imm ? entry_i.imm : rs2_data_i;
                alu_d.op = entry_i.op;
            end
        endcase
    end

    always_comb begin
        bnch_d.op1        = rs1_data_i;
        bnch_d.op2        = rs2_data_i;
        bnch_d.offset     = entry_i.imm;
        bnch_d.pc         = entry_i.pc;
        bnch_d.kind       = entry_i.kind;
        bnch_d.cond       = entry_i.op[2:0];
        bnch_d.rob_id     = entry_i.rob_id;
        bnch_d.dest       = entry_i.dest;
        bnch_d.pred_taken = entry_i.bm_pred[1];
        bnch_d.btb_vld    = entry_i.btb_vld;
        bnch_d.btb_target = entry_i.btb_target;
        bnch_d.valid      = live && !to_alu;
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            alu_req_o.valid  <= 1'b0;
            bnch_req_o.valid <= 1'b0;
            wakeup_valid_o   <= 1'b0;
        end else begin
            alu_req_o  <= alu_d;
            bnch_req_o <= bnch_d;
            // conditional branches never produce a register value.
            wakeup_valid_o <= live && (entry_i.kind != BRANCH) && (entry_i.dest != '0);
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        wakeup_dest_o <= entry_i.dest;
    end

endmodule

// ==== rtl/ex_issue_stage.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_issue_stage (
    input  logic                  cpu_clock_i,
    input  logic                  rst_i,

    input  logic                  req_i,
    output logic                  ack_o,
    input  ex_pkg::ex_entry_t     entry_i,

    output logic [`EX_PREG_W-1:0] rs1_addr_o,
    output logic [`EX_PREG_W-1:0] rs2_addr_o,
    output ex_pkg::ex_entry_t     entry_o,
    output logic                  entry_valid_o
);

    import ex_pkg::*;

    ex_entry_t entry_q;
    logic      capture;

    // a new request is taken only once the previous ack has dropped.
    assign capture = req_i && !ack_o;

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            ack_o         <= 1'b0;
            entry_valid_o <= 1'b0;
        end else begin
            entry_valid_o <= capture; // one pulse per transaction.
            if (capture) begin
                ack_o <= 1'b1;
            end else if (!req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (capture) begin
            entry_q <= entry_i;
        end
    end

    // the register file is addressed from the held entry.
    // operands are therefore ready while entry_valid_o is high.
    assign rs1_addr_o = entry_q.rs1;
    assign rs2_addr_o = entry_q.rs2;
    assign entry_o    = entry_q;

endmodule

// ==== rtl/ex_regfile.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_regfile (
    input  logic                  cpu_clock_i,
    input  logic                  rst_i,

    input  logic [`EX_PREG_W-1:0] rs1_addr_i,
    input  logic [`EX_PREG_W-1:0] rs2_addr_i,
    output logic [`EX_XLEN-1:0]   rs1_data_o,
    output logic [`EX_XLEN-1:0]   rs2_data_o,

    input  logic                  wr_en_i,
    input  logic [`EX_PREG_W-1:0] wr_addr_i,
    input  logic [`EX_XLEN-1:0]   wr_data_i
);

    logic [`EX_XLEN-1:0] regs [`EX_NPREG];

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            for (int i = 0; i < `EX_NPREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i; // register 0 stays zero.
        end
    end

    // reads see the array directly, so a write shows on the next cycle.
    always_comb begin
        rs1_data_o = regs[rs1_addr_i];
        rs2_data_o = regs[rs2_addr_i];
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;
        end
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end
    end

endmodule

// ==== rtl/ex_pkg.sv ====
`include "ex_consts.svh"

package ex_pkg;

    typedef enum logic [2:0] {
        ALU    = 3'd0,
        LUI    = 3'd1,
        AUIPC  = 3'd2,
        JAL    = 3'd3,
        JALR   = 3'd4,
        BRANCH = 3'd5
    } ex_kind_e;

    typedef struct packed {
        logic [`EX_ROB_W-1:0]  rob_id;
        logic [`EX_PREG_W-1:0] rs1;
        logic [`EX_PREG_W-1:0] rs2;
        logic [`EX_PREG_W-1:0] dest;
        ex_kind_e              kind;
        logic [3:0]            op;       // alu op, or branch condition in bits 2:0.
        logic                  use_imm;
        logic [`EX_XLEN-1:0]   imm;
        logic [`EX_PC_W-1:0]   pc;
        logic [1:0]            bm_pred;  // bit 1 set means predicted taken.
        logic                  btb_vld;
        logic [`EX_PC_W-1:0]   btb_target;
    } ex_entry_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]   a;
        logic [`EX_XLEN-1:0]   b;
        logic [3:0]            op;
        logic [`EX_ROB_W-1:0]  rob_id;
        logic [`EX_PREG_W-1:0] dest;
        logic                  valid;
    } ex_alu_req_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]   op1;
        logic [`EX_XLEN-1:0]   op2;
        logic [`EX_XLEN-1:0]   offset;
        logic [`EX_PC_W-1:0]   pc;
        ex_kind_e              kind;
        logic [2:0]            cond;
        logic [`EX_ROB_W-1:0]  rob_id;
        logic [`EX_PREG_W-1:0] dest;
        logic                  pred_taken;
        logic                  btb_vld;
        logic [`EX_PC_W-1:0]   btb_target;
        logic                  valid;
    } ex_bnch_req_t;

    typedef struct packed {
        logic                  taken;
        logic                  mispredict;
        logic [`EX_PC_W-1:0]   target;
    } ex_redirect_t;

    // one result word, read as alu data or as a redirect record.
    typedef union packed {
        logic [`EX_XLEN-1:0]   data;
        ex_redirect_t          redir;
    } ex_result_u;

    typedef struct packed {
        logic [`EX_ROB_W-1:0]  rob_id;
        logic [`EX_PREG_W-1:0] dest;     // zero when nothing is written.
        logic [`EX_XLEN-1:0]   link;
        ex_result_u            redirect;
        logic                  valid;
    } ex_bnch_res_t;

    typedef struct packed {
        logic [`EX_ROB_W-1:0]  rob_id;
        logic [`EX_PREG_W-1:0] dest;
        logic                  wr_en;
        logic                  is_branch;
        ex_result_u            result;
    } ex_done_t;

endpackage

// ==== rtl/ex_consts.svh ====
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define EX_XLEN   32
`define EX_PREG_W 6
`define EX_NPREG  64
`define EX_ROB_W  5
`define EX_PC_W   30

// alu operation codes carried in the op field of an entry.
`define EX_OP_ADD 4'd0
`define EX_OP_SUB 4'd1
`define EX_OP_AND 4'd2
`define EX_OP_OR  4'd3
`define EX_OP_XOR 4'd4
`define EX_OP_SLT 4'd5
`define EX_OP_SLL 4'd6
`define EX_OP_SRL 4'd7

`endif
